// ==== rtl/heap_pkg.sv ====
// shared word layout, reserved constants and block interfaces for the heap; import where used
package heap_pkg;

    // sizes
    localparam int word_sz   = 16;                  // bits per memory word
    localparam int addr_sz   = 8;                   // bits of a cell index
    localparam int mem_cells = 1 << addr_sz;        // 256 cells in the block RAM

    // type-tag masks
    localparam logic [word_sz-1:0] dir_tag = 16'h8000;  // fixnum when set, pointer when clear
    localparam logic [word_sz-1:0] mut_tag = 16'h4000;  // mutable vs rom
    localparam logic [word_sz-1:0] opq_tag = 16'h2000;  // opaque capability
    localparam logic [word_sz-1:0] vlt_tag = 16'h1000;  // volatile, heap storage

    // reserved constants
    localparam logic [word_sz-1:0] undef_word = 16'h0000;  // nothing here
    localparam logic [word_sz-1:0] nil_word   = 16'h0001;  // empty list, also end of free list
    localparam logic [word_sz-1:0] true_word  = 16'h0002;
    localparam logic [word_sz-1:0] false_word = 16'h0003;
    localparam logic [word_sz-1:0] unit_word  = 16'h0004;  // inert result
    localparam logic [word_sz-1:0] zero_fix   = dir_tag;   // fixnum +0

    // first heap pointer, index 0
    localparam logic [word_sz-1:0] heap_base = mut_tag | vlt_tag;  // 16'h5000

    // direct view, top bit set
    typedef struct packed {
        logic              dir;     // always 1 for a fixnum
        logic [14:0]       value;
    } heap_fix_t;

    // indirect view, top bit clear
    typedef struct packed {
        logic               dir;
        logic               mut;
        logic               opq;
        logic               vlt;
        logic [3:0]         rsvd;   // bit 0 doubles as carry of the top marker
        logic [addr_sz-1:0] idx;    // cell index into the RAM
    } heap_ptr_t;

    // one tagged word, decoded as fixnum or pointer by its top bit
    typedef union packed {
        logic [word_sz-1:0] raw;
        heap_fix_t          fix;
        heap_ptr_t          ptr;
    } heap_word_t;

    // one RAM command per cycle, from the controller
    typedef struct packed {
        logic               we;     // write strobe
        logic [addr_sz-1:0] waddr;
        heap_word_t         wdata;
        logic               re;     // read strobe
        logic [addr_sz-1:0] raddr;
        logic               pop;    // read is a free-list link, not a user read
    } heap_mem_cmd_t;

    // next free-list head coming back from the RAM
    typedef struct packed {
        logic       valid;  // one cycle after a pop
        heap_word_t word;
    } heap_link_t;

endpackage

// ==== rtl/heap_bram.sv ====
// heap storage; 256-word read-first block RAM, one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

module heap_bram (
    input  wire logic                   i_clk,
    input  wire heap_pkg::heap_mem_cmd_t i_cmd,     // write and read strobes, addresses
    output heap_pkg::heap_word_t        o_rdata     // valid one cycle after re
);
    import heap_pkg::*;

    heap_word_t mem [mem_cells];    // contents survive reset
    heap_word_t rdata_q;

    // single block keeps read-first order on an index collision
    always_ff @(posedge i_clk) begin
        if (i_cmd.we) begin
            mem[i_cmd.waddr] <= i_cmd.wdata;
        end
        if (i_cmd.re) begin
            rdata_q <= mem[i_cmd.raddr];    // old word on a same-cycle write
        end
        // holds last word when idle
    end

    assign o_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/heap_response.sv ====
// heap response stage; steers RAM read data to the user read port or back as a free-list link
`timescale 1ns/1ps
`default_nettype none

module heap_response (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,      // sync, active high
    input  wire heap_pkg::heap_mem_cmd_t i_cmd,     // same command the RAM sees
    input  wire heap_pkg::heap_word_t   i_rdata,    // RAM output
    output heap_pkg::heap_word_t        o_rdata,    // user read result
    output logic                        o_rd_valid, // one-cycle pulse per user read
    output heap_pkg::heap_link_t        o_link      // next free-list head after a pop
);
    import heap_pkg::*;

    logic user_rd_q;    // read in flight belongs to the memory port
    logic pop_rd_q;     // read in flight is a free-list link

    // captured at the same edge as the RAM read
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            user_rd_q <= 1'b0;
            pop_rd_q  <= 1'b0;
        end else begin
            user_rd_q <= i_cmd.re & ~i_cmd.pop;
            pop_rd_q  <= i_cmd.re & i_cmd.pop;
        end
    end

    // user side sees undef unless its own read returns
    always_comb begin
        o_rd_valid = user_rd_q;
        if (user_rd_q) begin
            o_rdata = i_rdata;
        end else begin
            o_rdata = undef_word;
        end
    end

    // controller side, valid only on the cycle after a pop
    assign o_link.valid = pop_rd_q;
    assign o_link.word  = i_rdata;

endmodule

`default_nettype wire

// ==== rtl/heap_alloc_ctrl.sv ====
// heap allocation controller; turns pointer and memory port requests into one RAM command a cycle
`timescale 1ns/1ps
`default_nettype none

module heap_alloc_ctrl (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,      // sync, active high

    input  wire logic                   i_alloc,    // allocation request
    input  wire heap_pkg::heap_word_t   i_data,     // initial word for the new cell
    input  wire logic                   i_free,     // free request
    input  wire heap_pkg::heap_word_t   i_addr,     // pointer being freed

    input  wire logic                   i_wr,       // memory write
    input  wire heap_pkg::heap_word_t   i_waddr,
    input  wire heap_pkg::heap_word_t   i_wdata,
    input  wire logic                   i_rd,       // memory read
    input  wire heap_pkg::heap_word_t   i_raddr,

    input  wire heap_pkg::heap_link_t   i_link,     // popped link from response stage

    output heap_pkg::heap_mem_cmd_t     o_cmd,      // to RAM and response stage
    output heap_pkg::heap_word_t        o_addr,     // allocated pointer, next cycle
    output logic                        o_err       // sticky until reset
);
    import heap_pkg::*;

    // request classification
    logic ptr_op;           // alloc and/or free
    logic mem_op;           // read and/or write
    logic bad_op;           // both ports at once
    logic oom_req;          // alloc that would pass the last cell
    logic err_set;
    logic run;              // this cycle is accepted

    logic alloc_op;
    logic free_op;
    logic write_op;
    logic read_op;
    logic raise_top;        // alloc served from the top marker
    logic pop_op;           // alloc served from the free list
    logic push_op;          // free that links the cell onto the list

    // heap state
    heap_word_t         top_q;      // next never-used cell
    logic [addr_sz:0]   free_cnt;   // cells on the free list, never negative
    heap_word_t         head_q;     // stored free-list head
    heap_word_t         head;       // live head, link wins when it just arrived
    logic               free_f;     // free list non-empty
    logic               top_carry;  // index wrapped past the last cell

    assign free_f    = (free_cnt != '0);
    assign top_carry = top_q.ptr.rsvd[0];   // bit addr_sz of the word
    assign head      = i_link.valid ? i_link.word : head_q;

    assign ptr_op  = i_alloc | i_free;
    assign mem_op  = i_wr | i_rd;
    assign bad_op  = ptr_op & mem_op;
    // lone alloc with no free cell and the top marker past the last cell
    assign oom_req = i_alloc & ~i_free & ~mem_op & ~free_f & top_carry;
    assign err_set = bad_op | oom_req;
    assign run     = ~o_err & ~err_set;     // nothing goes to the RAM once halted

    assign alloc_op  = i_alloc & run;
    assign free_op   = i_free & run;
    assign write_op  = i_wr & run;
    assign read_op   = i_rd & run;

    assign raise_top = alloc_op & ~free_op & ~free_f;
    assign pop_op    = alloc_op & ~free_op & free_f;
    assign push_op   = free_op & ~alloc_op;    // alloc+free just passes the cell through

    // RAM command
    always_comb begin
        o_cmd.we = alloc_op | free_op | write_op;

        if (free_op) begin
            o_cmd.waddr = i_addr.ptr.idx;       // freed cell, or passed-through alloc cell
        end else if (alloc_op) begin
            o_cmd.waddr = free_f ? head.ptr.idx : top_q.ptr.idx;
        end else begin
            o_cmd.waddr = i_waddr.ptr.idx;
        end

        if (alloc_op) begin
            o_cmd.wdata = i_data;               // initial contents
        end else if (free_op) begin
            o_cmd.wdata = head;                 // freed cell links to old head
        end else begin
            o_cmd.wdata = i_wdata;
        end

        // a pop reads the link and overwrites the same cell, the RAM is read-first
        o_cmd.re    = read_op | pop_op;
        o_cmd.raddr = pop_op ? head.ptr.idx : i_raddr.ptr.idx;
        o_cmd.pop   = pop_op;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_err    <= 1'b0;
            o_addr   <= undef_word;
            top_q    <= heap_base;
            free_cnt <= '0;
            head_q   <= nil_word;
        end else begin
            if (err_set) begin
                o_err <= 1'b1;  // halt, stays up until reset
            end
            if (run) begin
                // allocated pointer, undef in any non-alloc cycle
                if (alloc_op) begin
                    if (free_op) begin
                        o_addr <= i_addr;
                    end else if (free_f) begin
                        o_addr <= head;
                    end else begin
                        o_addr <= top_q;
                    end
                end else begin
                    o_addr <= undef_word;
                end

                if (raise_top) begin
                    top_q.raw <= top_q.raw + 1'b1;
                end

                // head tracking, a push overrides a link that just arrived
                if (push_op) begin
                    head_q <= i_addr;
                end else if (i_link.valid) begin
                    head_q <= i_link.word;
                end

                if (pop_op) begin
                    free_cnt <= free_cnt - 1'b1;
                end else if (push_op) begin
                    free_cnt <= free_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/heap_top.sv ====
// heap top level; connects controller, block RAM and response stage to the external ports
`timescale 1ns/1ps
`default_nettype none

module heap_top (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,      // sync, active high

    // pointer port
    input  wire logic                   i_alloc,
    input  wire heap_pkg::heap_word_t   i_data,     // initial word
    output heap_pkg::heap_word_t        o_addr,     // allocated pointer
    input  wire logic                   i_free,
    input  wire heap_pkg::heap_word_t   i_addr,     // pointer to free

    // memory port
    input  wire logic                   i_wr,
    input  wire heap_pkg::heap_word_t   i_waddr,
    input  wire heap_pkg::heap_word_t   i_wdata,
    input  wire logic                   i_rd,
    input  wire heap_pkg::heap_word_t   i_raddr,
    output heap_pkg::heap_word_t        o_rdata,
    output logic                        o_rd_valid, // pulses with o_rdata

    output logic                        o_err       // sticky halt
);
    import heap_pkg::*;

    heap_mem_cmd_t  cmd;        // controller to RAM and response
    heap_word_t     ram_rdata;  // RAM to response
    heap_link_t     link;       // response back to controller

    heap_alloc_ctrl u_ctrl (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_alloc (i_alloc),
        .i_data  (i_data),
        .i_free  (i_free),
        .i_addr  (i_addr),
        .i_wr    (i_wr),
        .i_waddr (i_waddr),
        .i_wdata (i_wdata),
        .i_rd    (i_rd),
        .i_raddr (i_raddr),
        .i_link  (link),
        .o_cmd   (cmd),
        .o_addr  (o_addr),
        .o_err   (o_err)
    );

    heap_bram u_bram (
        .i_clk   (i_clk),
        .i_cmd   (cmd),
        .o_rdata (ram_rdata)
    );

    heap_response u_resp (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_cmd      (cmd),
        .i_rdata    (ram_rdata),
        .o_rdata    (o_rdata),
        .o_rd_valid (o_rd_valid),
        .o_link     (link)
    );

endmodule

`default_nettype wire

// ==== testbench/heap_tb.sv ====
// self-checking testbench for heap_top; model-based compare over directed and random traffic
`timescale 1ns/1ps
`default_nettype none

module heap_tb;
    import heap_pkg::*;

    localparam int rst_cycles  = 16;
    localparam int rand_cycles = 400;
    // three resets, directed phases, random phase, full-heap fill
    localparam int plan_cycles = 3 * (rst_cycles + 1) + 60 + rand_cycles + mem_cells + 10;
    localparam int timeout_cycles = 2 * plan_cycles + 100;

    // what the outputs must show after one clock edge
    typedef struct packed {
        logic       chk;        // low while in reset
        heap_word_t addr;
        heap_word_t rdata;
        logic       rd_valid;
        logic       err;
    } expect_t;

    logic       i_clk = 1'b0;
    logic       i_rst;
    logic       i_alloc, i_free, i_wr, i_rd;
    heap_word_t i_data, i_addr, i_waddr, i_wdata, i_raddr;
    heap_word_t o_addr, o_rdata;
    logic       o_rd_valid, o_err;

    // reference heap
    heap_word_t ref_mem [mem_cells];
    heap_word_t ref_stack[$];   // free cells, last freed on top
    heap_word_t ref_addr;       // last o_addr
    int         ref_top;        // cells taken from the top marker
    logic       ref_err;

    heap_word_t live[$];        // pointers the tb may free, write or read
    expect_t    exp_next, exp_cur;
    logic [31:0] rng;
    int         cycle_count = 0;

    heap_top uut (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_alloc(i_alloc), .i_data(i_data), .o_addr(o_addr),
        .i_free(i_free), .i_addr(i_addr),
        .i_wr(i_wr), .i_waddr(i_waddr), .i_wdata(i_wdata),
        .i_rd(i_rd), .i_raddr(i_raddr), .o_rdata(o_rdata), .o_rd_valid(o_rd_valid),
        .o_err(o_err)
    );

    always #5 i_clk = ~i_clk;   // 10 ns period

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;  // upper bits, low ones cycle fast
    endfunction

    function automatic heap_word_t rand_word();
        logic [31:0] r;
        heap_word_t  w;
        r = lcg_next();
        w.raw = r[31:16];
        return w;
    endfunction

    // one cycle of the software heap, returns outputs due after the next edge
    function automatic expect_t ref_step(input logic a, input logic f, input logic w,
                                         input logic r, input heap_word_t data,
                                         input heap_word_t addr, input heap_word_t waddr,
                                         input heap_word_t wdata, input heap_word_t raddr);
        expect_t e;
        e = '0;
        e.chk = 1'b1;
        e.rdata = undef_word;
        if (!ref_err) begin
            if ((a | f) & (w | r)) begin
                ref_err = 1'b1;     // both ports at once
            end else if (a && !f && ref_stack.size() == 0 && ref_top == mem_cells) begin
                ref_err = 1'b1;     // out of cells
            end else begin
                if (r) begin
                    e.rd_valid = 1'b1;
                    e.rdata = ref_mem[raddr.ptr.idx];   // old word first
                end
                if (w) ref_mem[waddr.ptr.idx] = wdata;
                if (a && f) begin
                    ref_addr = addr;                    // freed cell handed straight back
                end else if (a && ref_stack.size() > 0) begin
                    ref_addr = ref_stack.pop_back();
                end else if (a) begin
                    ref_addr.raw = heap_base + 16'(ref_top);
                    ref_top++;
                end else begin
                    ref_addr = undef_word;
                end
                if (a) ref_mem[ref_addr.ptr.idx] = data;
                if (f && !a) begin
                    // freed cell stores the old head as its link
                    if (ref_stack.size() > 0) ref_mem[addr.ptr.idx] = ref_stack[$];
                    else ref_mem[addr.ptr.idx] = nil_word;
                    ref_stack.push_back(addr);
                end
            end
        end
        e.addr = ref_addr;
        e.err = ref_err;
        return e;
    endfunction

    task automatic check_word(input string name, input heap_word_t got, input heap_word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got.raw, exp.raw);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // expectation for the edge just taken, compared half a cycle later
    always @(posedge i_clk) exp_cur <= exp_next;

    always @(negedge i_clk) begin
        if (exp_cur.chk) begin
            check_word("o_addr", o_addr, exp_cur.addr);
            check_word("o_rdata", o_rdata, exp_cur.rdata);
            check_bit("o_rd_valid", o_rd_valid, exp_cur.rd_valid);
            check_bit("o_err", o_err, exp_cur.err);
        end
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    task automatic drive_cycle(input logic a, input logic f, input logic w, input logic r,
                               input heap_word_t data, input heap_word_t addr,
                               input heap_word_t waddr, input heap_word_t wdata,
                               input heap_word_t raddr);
        @(posedge i_clk);
        #1;
        i_alloc = a;
        i_free  = f;
        i_wr    = w;
        i_rd    = r;
        i_data  = data;
        i_addr  = addr;
        i_waddr = waddr;
        i_wdata = wdata;
        i_raddr = raddr;
        exp_next = ref_step(a, f, w, r, data, addr, waddr, wdata, raddr);
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, undef_word, undef_word, undef_word, undef_word,
                    undef_word);
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        #1;
        i_rst = 1'b1;
        {i_alloc, i_free, i_wr, i_rd} = 4'b0000;
        exp_next.chk = 1'b0;
        repeat (rst_cycles) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        ref_stack.delete();     // RAM contents kept, as in the DUT
        live.delete();
        ref_addr = undef_word;
        ref_top = 0;
        ref_err = 1'b0;
    endtask

    task automatic alloc_cell(input heap_word_t data);
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, data, undef_word, undef_word, undef_word,
                    undef_word);
        if (!ref_err) live.push_back(ref_addr);
    endtask

    task automatic release_cell(input int k);
        heap_word_t p;
        p = live[k];
        live.delete(k);
        drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, undef_word, p, undef_word, undef_word, undef_word);
    endtask

    // alloc and free together, cell stays live
    task automatic pass_through(input int k, input heap_word_t data);
        drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, data, live[k], undef_word, undef_word, undef_word);
    endtask

    task automatic write_cell(input int k, input heap_word_t data);
        drive_cycle(1'b0, 1'b0, 1'b1, 1'b0, undef_word, undef_word, live[k], data, undef_word);
    endtask

    task automatic read_cell(input int k);
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, undef_word, undef_word, undef_word, undef_word,
                    live[k]);
    endtask

    task automatic random_op();
        int  op;
        logic room;
        op = rand_below(10);
        room = (ref_top < mem_cells) || (ref_stack.size() > 0);
        if (live.size() == 0 || op < 3) begin
            if (room) alloc_cell(rand_word());
            else idle_cycle();
        end else if (op < 5) begin
            release_cell(rand_below(live.size()));
        end else if (op < 7) begin
            write_cell(rand_below(live.size()), rand_word());
        end else if (op < 9) begin
            read_cell(rand_below(live.size()));
        end else begin
            idle_cycle();
        end
    endtask

    initial begin
        heap_word_t last_ptr;
        i_rst = 1'b1;
        {i_alloc, i_free, i_wr, i_rd} = 4'b0000;
        i_data = undef_word;
        i_addr = undef_word;
        i_waddr = undef_word;
        i_wdata = undef_word;
        i_raddr = undef_word;
        exp_next = '0;
        rng = 32'd46;
        apply_reset();

        for (int i = 0; i < 8; i++) alloc_cell(rand_word());   // fresh cells from 5000
        for (int i = 0; i < 8; i++) read_cell(i);
        idle_cycle();
        for (int i = 0; i < 4; i++) write_cell(i, rand_word());
        idle_cycle();
        for (int i = 0; i < 4; i++) begin
            read_cell(i);
            idle_cycle();   // gap shows rd_valid low and undef addr
        end

        for (int i = 0; i < 5; i++) release_cell(1);    // frees 5001 through 5005
        for (int i = 0; i < 8; i++) alloc_cell(rand_word());    // lifo, then top again
        pass_through(0, rand_word());
        alloc_cell(rand_word());

        for (int n = 0; n < rand_cycles; n++) random_op();
        idle_cycle();
        idle_cycle();

        // pointer and memory request together
        apply_reset();
        alloc_cell(rand_word());    // o_addr at 5000 when the halt hits
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b1, rand_word(), undef_word, undef_word, undef_word,
                    heap_base);
        repeat (3) idle_cycle();
        alloc_cell(rand_word());    // ignored while halted
        idle_cycle();
        @(negedge i_clk);
        check_bit("o_err", o_err, 1'b1);

        // fill every cell, one more must halt
        apply_reset();
        for (int i = 0; i < mem_cells; i++) alloc_cell(rand_word());
        alloc_cell(rand_word());
        idle_cycle();
        idle_cycle();
        @(negedge i_clk);
        last_ptr.raw = heap_base + 16'(mem_cells - 1);
        check_bit("o_err", o_err, 1'b1);
        check_word("o_addr", o_addr, last_ptr);    // held at the last good cell

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/heap_pkg.sv
rtl/heap_bram.sv
rtl/heap_response.sv
rtl/heap_alloc_ctrl.sv
rtl/heap_top.sv
testbench/heap_tb.sv

// ==== Makefile ====
# Verilator build and run for the heap testbench

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= heap_tb
RTL_TOP   ?= heap_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
PASS_STR  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
